/* pcore_config.svh */
`ifndef PCORE_CONFIG_SVH
`define PCORE_CONFIG_SVH

// Core data bus width, address and data
`define XLEN 32

// GPIO pin count
`define GPIO_WIDTH 8

// GPIO window base on the data bus, 4 KB aligned
`define GPIO_BASE 32'h8000_1000

// Offset bits inside one peripheral window
`define PERIPH_ADDR_BITS 12

`endif

/* dbus_pkg.sv */
`include "pcore_config.svh"

package dbus_pkg;

  // Full byte address as issued by the core
  typedef logic [`XLEN-1:0] dbus_addr_t;

  // Read and write data word
  typedef logic [`XLEN-1:0] dbus_data_t;

  // One enable per byte lane
  typedef logic [`XLEN/8-1:0] dbus_mask_t;

  // Address bits left after the window decode
  typedef logic [`PERIPH_ADDR_BITS-1:0] periph_offset_t;

endpackage : dbus_pkg

/* gpio_pkg.sv */
`include "pcore_config.svh"

package gpio_pkg;

  // One bit per pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // Register map inside the GPIO window
  typedef enum logic [`PERIPH_ADDR_BITS-1:0] {
    GPIO_OUT      = 'h000,  // Output data, rw
    GPIO_DIR      = 'h004,  // 1 = output, rw
    GPIO_IN       = 'h008,  // Synchronized pins, ro
    GPIO_IRQ_EN   = 'h00C,  // Interrupt enables, rw
    GPIO_IRQ_PEND = 'h010   // Pending edges, write 1 to clear
  } gpio_reg_e;

endpackage : gpio_pkg

/* periph_bus_if.sv */
interface periph_bus_if;

  import dbus_pkg::*;
  import gpio_pkg::*;

  logic           sel;     // Registered hit, one cycle
  logic           wr;
  periph_offset_t offset;
  dbus_mask_t     mask;
  dbus_data_t     wdata;
  gpio_word_t     rdata;   // Combinational from offset

  modport decoder (
    output sel,
    output wr,
    output offset,
    output mask,
    output wdata,
    input  rdata
  );

  modport target (
    input  sel,
    input  wr,
    input  offset,
    input  mask,
    input  wdata,
    output rdata
  );

endinterface : periph_bus_if

/* gpio_ctrl_if.sv */
interface gpio_ctrl_if;

  import gpio_pkg::*;

  gpio_word_t out_data;
  gpio_word_t dir;
  gpio_word_t irq_en;
  gpio_word_t clr_pend;  // Bits to clear, valid with clr_we
  logic       clr_we;
  gpio_word_t in_sync;
  gpio_word_t pend;

  modport regs (
    output out_data, dir, irq_en, clr_pend, clr_we,
    input  in_sync, pend
  );

  modport port (
    input  out_data, dir, irq_en, clr_pend, clr_we,
    output in_sync, pend
  );

endinterface : gpio_ctrl_if

/* dbus_decoder.sv */
`include "pcore_config.svh"

module dbus_decoder (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dbus_req_i,
  input  logic                dbus_wr_i,
  input  dbus_pkg::dbus_addr_t dbus_addr_i,
  input  dbus_pkg::dbus_mask_t dbus_mask_i,
  input  dbus_pkg::dbus_data_t dbus_wdata_i,
  output dbus_pkg::dbus_data_t dbus_rdata_o,
  output logic                dbus_ack_o,
  output logic                dbus_err_o,
  periph_bus_if.decoder       bus
);

  import dbus_pkg::*;

  localparam dbus_addr_t BASE = `GPIO_BASE;

  logic           hit;
  logic           ack_q;
  logic           err_q;
  logic           sel_q;
  logic           wr_q;
  periph_offset_t offset_q;
  dbus_mask_t     mask_q;
  dbus_data_t     wdata_q;

  // Window match on the bits above the offset
  assign hit = (dbus_addr_i[`XLEN-1:`PERIPH_ADDR_BITS] == BASE[`XLEN-1:`PERIPH_ADDR_BITS]);

  // Request strobes, one edge after req
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      ack_q <= dbus_req_i;
      err_q <= dbus_req_i & ~hit;
      sel_q <= dbus_req_i & hit;
    end
  end

  // Payload, captured with every request
  always_ff @(posedge clk) begin
    if (dbus_req_i) begin
      wr_q     <= dbus_wr_i;
      offset_q <= dbus_addr_i[`PERIPH_ADDR_BITS-1:0];
      mask_q   <= dbus_mask_i;
      wdata_q  <= dbus_wdata_i;
    end
  end

  assign bus.sel    = sel_q;
  assign bus.wr     = wr_q;
  assign bus.offset = offset_q;
  assign bus.mask   = mask_q;
  assign bus.wdata  = wdata_q;

  assign dbus_ack_o = ack_q;
  assign dbus_err_o = err_q;

  // Only a read hit returns data, zero extended from the pin width
  always_comb begin
    dbus_rdata_o = '0;
    if (sel_q && !wr_q) begin
      dbus_rdata_o = dbus_data_t'(bus.rdata);
    end
  end

endmodule : dbus_decoder

/* gpio_regs.sv */
`include "pcore_config.svh"

module gpio_regs (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.target bus,
  gpio_ctrl_if.regs    ctrl
);

  import gpio_pkg::*;

  logic       we;
  gpio_word_t wbyte;
  gpio_word_t out_q;
  gpio_word_t dir_q;
  gpio_word_t irq_en_q;

  // Only byte lane 0 carries pin data
  assign we    = bus.sel & bus.wr & bus.mask[0];
  assign wbyte = bus.wdata[`GPIO_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst_n) begin
      out_q    <= '0;
      dir_q    <= '0;
      irq_en_q <= '0;
    end else if (we) begin
      case (bus.offset)
        GPIO_OUT:    out_q    <= wbyte;
        GPIO_DIR:    dir_q    <= wbyte;
        GPIO_IRQ_EN: irq_en_q <= wbyte;
        default: ;  // IN is read-only, PEND handled in port
      endcase
    end
  end

  // Read mux, unmapped offsets return zero
  always_comb begin
    case (bus.offset)
      GPIO_OUT:      bus.rdata = out_q;
      GPIO_DIR:      bus.rdata = dir_q;
      GPIO_IN:       bus.rdata = ctrl.in_sync;
      GPIO_IRQ_EN:   bus.rdata = irq_en_q;
      GPIO_IRQ_PEND: bus.rdata = ctrl.pend;
      default:       bus.rdata = '0;
    endcase
  end

  // Write 1 to clear on the pending register
  assign ctrl.clr_we   = we && (bus.offset == GPIO_IRQ_PEND);
  assign ctrl.clr_pend = wbyte;

  assign ctrl.out_data = out_q;
  assign ctrl.dir      = dir_q;
  assign ctrl.irq_en   = irq_en_q;

endmodule : gpio_regs

/* gpio_port.sv */
module gpio_port (
  input  logic                 clk,
  input  logic                 rst_n,
  gpio_ctrl_if.port            ctrl,
  input  gpio_pkg::gpio_word_t gpio_port_i,
  output gpio_pkg::gpio_word_t gpio_port_o,
  output gpio_pkg::gpio_word_t gpio_oe_o,
  output logic                 gpio_irq_o
);

  import gpio_pkg::*;

  gpio_word_t sync1_q;
  gpio_word_t sync2_q;
  gpio_word_t prev_q;
  gpio_word_t pend_q;
  gpio_word_t rise;
  gpio_word_t clr;

  assign gpio_port_o = ctrl.out_data;
  assign gpio_oe_o   = ctrl.dir;

  // Two-flop synchronizer, then one more stage for edge detect
  always_ff @(posedge clk) begin
    if (rst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_port_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Rising edges count on input pins only
  assign rise = sync2_q & ~prev_q & ~ctrl.dir;
  assign clr  = ctrl.clr_we ? ctrl.clr_pend : '0;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~clr) | rise;  // Set wins over clear
    end
  end

  assign ctrl.in_sync = sync2_q;
  assign ctrl.pend    = pend_q;

  assign gpio_irq_o = |(pend_q & ctrl.irq_en);

endmodule : gpio_port

/* periph_top.sv */
module periph_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core data bus
  input  logic                 dbus_req_i,
  input  logic                 dbus_wr_i,
  input  dbus_pkg::dbus_addr_t dbus_addr_i,
  input  dbus_pkg::dbus_mask_t dbus_mask_i,
  input  dbus_pkg::dbus_data_t dbus_wdata_i,
  output dbus_pkg::dbus_data_t dbus_rdata_o,
  output logic                 dbus_ack_o,
  output logic                 dbus_err_o,

  // Pins
  input  gpio_pkg::gpio_word_t gpio_port_i,
  output gpio_pkg::gpio_word_t gpio_port_o,
  output gpio_pkg::gpio_word_t gpio_oe_o,
  output logic                 gpio_irq_o
);

  periph_bus_if bus_if ();
  gpio_ctrl_if  ctrl_if ();

  dbus_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .dbus_req_i   (dbus_req_i),
    .dbus_wr_i    (dbus_wr_i),
    .dbus_addr_i  (dbus_addr_i),
    .dbus_mask_i  (dbus_mask_i),
    .dbus_wdata_i (dbus_wdata_i),
    .dbus_rdata_o (dbus_rdata_o),
    .dbus_ack_o   (dbus_ack_o),
    .dbus_err_o   (dbus_err_o),
    .bus          (bus_if.decoder)
  );

  gpio_regs u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus_if.target),
    .ctrl  (ctrl_if.regs)
  );

  gpio_port u_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl_if.port),
    .gpio_port_i (gpio_port_i),
    .gpio_port_o (gpio_port_o),
    .gpio_oe_o   (gpio_oe_o),
    .gpio_irq_o  (gpio_irq_o)
  );

endmodule : periph_top

/* periph_checker.sv */
module periph_checker (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_i,
  input logic                 ack_i,
  input logic                 err_i,
  input logic                 irq_i,
  input gpio_pkg::gpio_word_t pend_i,
  input gpio_pkg::gpio_word_t irq_en_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Ack exactly one edge after req
  ack_follows_req: assert property (@(posedge clk) disable iff (rst_n)
    req_i |=> ack_i)
    else $error("ack missing one cycle after request");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst_n)
    ack_i |-> $past(req_i))
    else $error("ack without a request on the previous edge");

  err_with_ack: assert property (@(posedge clk) disable iff (rst_n)
    err_i |-> ack_i)
    else $error("err raised outside an ack cycle");

  // No enabled pending bit, no interrupt
  irq_needs_pend: assert property (@(posedge clk) disable iff (rst_n)
    ((pend_i & irq_en_i) == '0) |-> !irq_i)
    else $error("irq high with no enabled pending bit");

endmodule : periph_checker

bind periph_top periph_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_i    (dbus_req_i),
  .ack_i    (dbus_ack_o),
  .err_i    (dbus_err_o),
  .irq_i    (gpio_irq_o),
  .pend_i   (ctrl_if.pend),
  .irq_en_i (ctrl_if.irq_en)
);

/* tb_periph_top.sv */
`include "pcore_config.svh"

module tb_periph_top;

  timeunit 1ns;
  timeprecision 100ps;

  import dbus_pkg::*;
  import gpio_pkg::*;

  localparam dbus_addr_t  BASE_ADDR       = `GPIO_BASE;
  localparam int          ACK_TIMEOUT     = 8;
  // Six short tests, the longest under 100 cycles, so 2000 leaves ample margin
  localparam int          WATCHDOG_CYCLES = 2000;
  localparam int unsigned RAND_SEED       = 32'h052be903;

  logic       clk;
  logic       rst_n;
  logic       dbus_req_i;
  logic       dbus_wr_i;
  dbus_addr_t dbus_addr_i;
  dbus_mask_t dbus_mask_i;
  dbus_data_t dbus_wdata_i;
  dbus_data_t dbus_rdata_o;
  logic       dbus_ack_o;
  logic       dbus_err_o;
  gpio_word_t gpio_port_i;
  gpio_word_t gpio_port_o;
  gpio_word_t gpio_oe_o;
  logic       gpio_irq_o;

  int          errors;
  int          checks;
  int          tests;
  int          test_start_errors;
  string       test_name;

  periph_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .dbus_req_i   (dbus_req_i),
    .dbus_wr_i    (dbus_wr_i),
    .dbus_addr_i  (dbus_addr_i),
    .dbus_mask_i  (dbus_mask_i),
    .dbus_wdata_i (dbus_wdata_i),
    .dbus_rdata_o (dbus_rdata_o),
    .dbus_ack_o   (dbus_ack_o),
    .dbus_err_o   (dbus_err_o),
    .gpio_port_i  (gpio_port_i),
    .gpio_port_o  (gpio_port_o),
    .gpio_oe_o    (gpio_oe_o),
    .gpio_irq_o   (gpio_irq_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic dbus_addr_t window_addr(input periph_offset_t off);
    return {BASE_ADDR[`XLEN-1:`PERIPH_ADDR_BITS], off};
  endfunction

  task automatic check_data(input string what, input dbus_data_t exp, input dbus_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_pins(input string what, input gpio_word_t exp, input gpio_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch [%s] %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic report_test;
    tests++;
    $display("test %-16s %s, %0d errors", test_name,
             (errors == test_start_errors) ? "ok" : "failed", errors - test_start_errors);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Sets up one request, called on a falling edge
  task automatic drive_request(input logic wr, input dbus_addr_t addr, input dbus_data_t wdata);
    dbus_req_i   = 1'b1;
    dbus_wr_i    = wr;
    dbus_addr_i  = addr;
    dbus_mask_i  = 4'h1;
    dbus_wdata_i = wdata;
  endtask

  task automatic bus_access(input logic wr, input dbus_addr_t addr, input dbus_mask_t mask,
                            input dbus_data_t wdata, output dbus_data_t rdata,
                            output logic err);
    int waited;
    waited       = 0;
    dbus_req_i   = 1'b1;
    dbus_wr_i    = wr;
    dbus_addr_i  = addr;
    dbus_mask_i  = mask;
    dbus_wdata_i = wdata;
    @(negedge clk);
    dbus_req_i = 1'b0;  // One-cycle pulse
    while (!dbus_ack_o && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!dbus_ack_o) begin
      errors++;
      $display("[%s] no ack received for access to address %h", test_name, addr);
    end
    rdata = dbus_rdata_o;
    err   = dbus_err_o;
  endtask

  task automatic bus_write(input dbus_addr_t addr, input dbus_mask_t mask,
                           input dbus_data_t wdata);
    dbus_data_t rdata;
    logic       err;
    bus_access(1'b1, addr, mask, wdata, rdata, err);
    check_bit("write err flag", 1'b0, err);
    check_data("write ack data", '0, rdata);
    @(negedge clk);  // Register update lands on the edge that ends the ack
  endtask

  task automatic bus_read(input dbus_addr_t addr, output dbus_data_t rdata);
    logic err;
    bus_access(1'b0, addr, 4'hF, '0, rdata, err);
    check_bit("read err flag", 1'b0, err);
  endtask

  task automatic reset_values;
    gpio_reg_e  regs [5] = '{GPIO_OUT, GPIO_DIR, GPIO_IN, GPIO_IRQ_EN, GPIO_IRQ_PEND};
    dbus_data_t rdata;
    begin_test("reset_values");
    check_pins("port after reset", '0, gpio_port_o);
    check_pins("oe after reset", '0, gpio_oe_o);
    check_bit("irq after reset", 1'b0, gpio_irq_o);
    foreach (regs[i]) begin
      bus_read(window_addr(regs[i]), rdata);
      check_data(regs[i].name(), '0, rdata);
    end
    report_test();
  endtask

  task automatic write_readback;
    dbus_data_t rdata;
    begin_test("write_readback");
    bus_write(window_addr(GPIO_OUT), 4'h1, 32'h1234_56A5);  // Upper lanes ignored
    bus_write(window_addr(GPIO_DIR), 4'h1, 32'h0000_003C);
    check_pins("port pins", 8'hA5, gpio_port_o);
    check_pins("oe pins", 8'h3C, gpio_oe_o);
    bus_read(window_addr(GPIO_OUT), rdata);
    check_data("out readback", 32'h0000_00A5, rdata);
    bus_read(window_addr(GPIO_DIR), rdata);
    check_data("dir readback", 32'h0000_003C, rdata);
    // Lane 0 disabled, nothing may change
    bus_write(window_addr(GPIO_OUT), 4'hE, 32'hFFFF_FFFF);
    check_pins("port after masked write", 8'hA5, gpio_port_o);
    bus_read(window_addr(GPIO_OUT), rdata);
    check_data("out after masked write", 32'h0000_00A5, rdata);
    report_test();
  endtask

  task automatic input_sampling;
    gpio_word_t  pattern;
    int unsigned rnd;
    dbus_data_t  rdata;
    begin_test("input_sampling");
    for (int i = 0; i < 8; i++) begin
      rnd         = $urandom();
      pattern     = rnd[`GPIO_WIDTH-1:0];
      gpio_port_i = pattern;
      idle_cycles(3);  // Two sync stages plus one
      bus_read(window_addr(GPIO_IN), rdata);
      check_data("gpio_in", dbus_data_t'(pattern), rdata);
    end
    report_test();
  endtask

  task automatic window_decode;
    dbus_data_t rdata;
    logic       err;
    begin_test("window_decode");
    bus_write(window_addr(GPIO_OUT), 4'h1, 32'h0000_0096);
    bus_access(1'b0, 32'h8000_2008, 4'hF, '0, rdata, err);  // Next window up
    check_bit("read miss err", 1'b1, err);
    check_data("read miss data", '0, rdata);
    bus_access(1'b1, 32'h0000_1000, 4'h1, 32'hFF, rdata, err);
    check_bit("write miss err", 1'b1, err);
    check_data("write miss data", '0, rdata);
    check_pins("port after miss write", 8'h96, gpio_port_o);
    bus_read(window_addr(12'h020), rdata);
    check_data("unmapped read", '0, rdata);
    bus_write(window_addr(12'h014), 4'h1, 32'h0000_00FF);
    check_pins("port after unmapped write", 8'h96, gpio_port_o);
    check_pins("oe after unmapped write", 8'h3C, gpio_oe_o);
    report_test();
  endtask

  task automatic edge_interrupt;
    dbus_data_t rdata;
    begin_test("edge_interrupt");
    bus_write(window_addr(GPIO_DIR), 4'h1, 32'h0000_00F0);  // Pins 7:4 outputs
    gpio_port_i = '0;
    idle_cycles(4);
    bus_write(window_addr(GPIO_IRQ_PEND), 4'h1, 32'h0000_00FF);  // Drop earlier edges
    bus_read(window_addr(GPIO_IRQ_PEND), rdata);
    check_data("pend cleared", '0, rdata);
    check_bit("irq idle", 1'b0, gpio_irq_o);
    gpio_port_i = 8'hFF;
    idle_cycles(4);
    bus_read(window_addr(GPIO_IRQ_PEND), rdata);
    check_data("pend on input pins", 32'h0000_000F, rdata);
    check_bit("irq with no enable", 1'b0, gpio_irq_o);
    bus_write(window_addr(GPIO_IRQ_EN), 4'h1, 32'h0000_0010);
    check_bit("irq on output pin enable", 1'b0, gpio_irq_o);
    bus_write(window_addr(GPIO_IRQ_EN), 4'h1, 32'h0000_0012);
    check_bit("irq on pin 1 enable", 1'b1, gpio_irq_o);
    bus_write(window_addr(GPIO_IRQ_PEND), 4'h1, 32'h0000_0002);
    check_bit("irq after clear", 1'b0, gpio_irq_o);
    bus_read(window_addr(GPIO_IRQ_PEND), rdata);
    check_data("pend after clear", 32'h0000_000D, rdata);
    report_test();
  endtask

  // Each request is issued in the cycle of the previous ack
  task automatic back_to_back;
    begin_test("back_to_back");
    drive_request(1'b0, window_addr(GPIO_OUT), '0);
    @(negedge clk);
    check_bit("ack 1", 1'b1, dbus_ack_o);
    check_data("read out", 32'h0000_0096, dbus_rdata_o);
    drive_request(1'b0, window_addr(GPIO_DIR), '0);
    @(negedge clk);
    check_bit("ack 2", 1'b1, dbus_ack_o);
    check_data("read dir", 32'h0000_00F0, dbus_rdata_o);
    drive_request(1'b1, window_addr(GPIO_OUT), 32'h0000_005A);
    @(negedge clk);
    check_bit("ack 3", 1'b1, dbus_ack_o);
    check_data("write data", '0, dbus_rdata_o);
    drive_request(1'b0, window_addr(GPIO_OUT), '0);
    @(negedge clk);
    dbus_req_i = 1'b0;
    check_bit("ack 4", 1'b1, dbus_ack_o);
    check_data("read new out", 32'h0000_005A, dbus_rdata_o);
    check_bit("err in burst", 1'b0, dbus_err_o);
    @(negedge clk);
    check_bit("no extra ack", 1'b0, dbus_ack_o);
    report_test();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b1;  // Reset is active high
    dbus_req_i   = 1'b0;
    dbus_wr_i    = 1'b0;
    dbus_addr_i  = '0;
    dbus_mask_i  = '0;
    dbus_wdata_i = '0;
    gpio_port_i  = '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    test_name    = "init";
    void'($urandom(RAND_SEED));
    repeat (5) @(negedge clk);
    rst_n = 1'b0;
    reset_values();
    write_readback();
    input_sampling();
    window_decode();
    edge_interrupt();
    back_to_back();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_periph_top

/* vlog.f */
+incdir+.
dbus_pkg.sv
gpio_pkg.sv
periph_bus_if.sv
gpio_ctrl_if.sv
dbus_decoder.sv
gpio_regs.sv
gpio_port.sv
periph_top.sv
periph_checker.sv
tb_periph_top.sv

/* Makefile */
# Verilator simulation of the GPIO peripheral

TOP := tb_periph_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
